// File: source/fe_pkg.sv
package fe_pkg;

    // Instruction word and PC width
    localparam int XLEN = 32;

    // Register specifier width
    localparam int REG_W = 4;

    // Opcode field
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 28;

    // Destination register field
    localparam int RD_MSB = 27;
    localparam int RD_LSB = 24;

    // First source register
    localparam int RS1_MSB = 23;
    localparam int RS1_LSB = 20;

    // Second source register
    localparam int RS2_MSB = 19;
    localparam int RS2_LSB = 16;

    // Immediate, sign-extended to XLEN in decode
    localparam int IMM_MSB = 15;
    localparam int IMM_LSB = 0;
    localparam int IMM_W = IMM_MSB - IMM_LSB + 1;

    // One queue entry, PC in the upper half
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } ibuf_entry_t;

    // Field values 0..7 follow this order, 8..15 are illegal
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_ILLEGAL
    } op_e;

endpackage

// File: source/fetch_group_if.sv
`timescale 1ns/100ps

interface fetch_group_if #(
    parameter int IF_WIDTH = 2
);

    // Slot valid bits, always a prefix from slot 0
    logic [IF_WIDTH-1:0] valid;
    // Per-slot PC and instruction word
    logic [fe_pkg::XLEN-1:0] pc [IF_WIDTH];
    logic [fe_pkg::XLEN-1:0] instr [IF_WIDTH];
    // Buffer near full, fetch must hold off
    logic stall;

    modport fetch (
        output valid,
        output pc,
        output instr,
        input  stall
    );

    modport buffer (
        input  valid,
        input  pc,
        input  instr,
        output stall
    );

endinterface

// File: source/instr_fetch.sv
`timescale 1ns/100ps

module instr_fetch #(
    parameter int IF_WIDTH = 2
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             redirect_i,
    input  logic [fe_pkg::XLEN-1:0]          redirect_pc_i,
    output logic                             imem_req_o,
    output logic [fe_pkg::XLEN-1:0]          imem_addr_o,
    input  logic [IF_WIDTH*fe_pkg::XLEN-1:0] imem_rdata_i,
    fetch_group_if.fetch                     grp
);

    // Offset of a word inside its group
    localparam int OFS_W = (IF_WIDTH > 1) ? $clog2(IF_WIDTH) : 1;
    localparam logic [fe_pkg::XLEN-1:0] OFS_MASK = IF_WIDTH - 1;

    logic                    run_q;
    logic [fe_pkg::XLEN-1:0] fetch_pc;
    logic [fe_pkg::XLEN-1:0] grp_base;
    logic [OFS_W-1:0]        fetch_ofs;

    // Request in flight and where it started
    logic                    pend_q;
    logic [fe_pkg::XLEN-1:0] pend_pc;
    logic [OFS_W-1:0]        pend_ofs;

    assign grp_base  = fetch_pc & ~OFS_MASK;
    assign fetch_ofs = OFS_W'(fetch_pc & OFS_MASK);

    // No request until the first clock out of reset
    assign imem_req_o  = run_q & ~grp.stall;
    assign imem_addr_o = grp_base;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q    <= 1'b0;
            pend_q   <= 1'b0;
            fetch_pc <= '0;
        end else begin
            run_q <= 1'b1;
            // Redirect kills whatever is requested this cycle
            pend_q <= imem_req_o & ~redirect_i;
            if (redirect_i) begin
                fetch_pc <= redirect_pc_i;
            end else if (imem_req_o) begin
                // Skip to the next aligned group
                fetch_pc <= grp_base + IF_WIDTH;
            end
        end
    end

    // Start PC and offset of the pending group
    always_ff @(posedge clk) begin
        if (imem_req_o) begin
            pend_pc  <= fetch_pc;
            pend_ofs <= fetch_ofs;
        end
    end

    // Shift words at and above the start offset down to slot 0
    always_comb begin
        int src;
        for (int i = 0; i < IF_WIDTH; i++) begin
            src = int'(pend_ofs) + i;
            grp.pc[i] = pend_pc + i;
            if (src < IF_WIDTH) begin
                grp.valid[i] = pend_q;
                grp.instr[i] = imem_rdata_i[src*fe_pkg::XLEN +: fe_pkg::XLEN];
            end else begin
                // Slots past the group end
                grp.valid[i] = 1'b0;
                grp.instr[i] = '0;
            end
        end
    end

endmodule

// File: source/instr_buffer.sv
`timescale 1ns/100ps

module instr_buffer #(
    parameter int IF_WIDTH    = 2,
    parameter int ID_WIDTH    = 2,
    parameter int BUFFER_SIZE = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush_i,
    fetch_group_if.buffer       grp,
    input  logic [ID_WIDTH-1:0] accept_i,
    output fe_pkg::ibuf_entry_t head_o [ID_WIDTH],
    output logic [ID_WIDTH-1:0] head_valid_o
);

    localparam int PTR_W = $clog2(BUFFER_SIZE);
    // One extra bit so full and empty differ
    localparam int CNT_W = PTR_W + 1;
    // Leaves room for the group already in flight
    localparam int STALL_LVL = BUFFER_SIZE - 2 * IF_WIDTH;

    fe_pkg::ibuf_entry_t queue [BUFFER_SIZE];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] push_num;
    logic [CNT_W-1:0] pop_num;

    // Wrapped slot addresses
    logic [PTR_W-1:0] wr_idx [IF_WIDTH];
    logic [PTR_W-1:0] rd_idx [ID_WIDTH];

    // Popcount of incoming valid slots
    always_comb begin
        push_num = '0;
        for (int i = 0; i < IF_WIDTH; i++) begin
            push_num = push_num + CNT_W'(grp.valid[i]);
        end
    end

    // Popcount of accepted slots, only those actually valid
    always_comb begin
        pop_num = '0;
        for (int i = 0; i < ID_WIDTH; i++) begin
            pop_num = pop_num + CNT_W'(accept_i[i] & head_valid_o[i]);
        end
    end

    always_comb begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            wr_idx[i] = wr_ptr + PTR_W'(i);
        end
        for (int i = 0; i < ID_WIDTH; i++) begin
            rd_idx[i] = rd_ptr + PTR_W'(i);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            // Branch miss drops everything queued
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + PTR_W'(pop_num);
            wr_ptr <= wr_ptr + PTR_W'(push_num);
            count  <= count + push_num - pop_num;
        end
    end

    // Multi-write, prefix slots land at consecutive addresses
    always_ff @(posedge clk) begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            if (grp.valid[i] && !flush_i) begin
                queue[wr_idx[i]].pc    <= grp.pc[i];
                queue[wr_idx[i]].instr <= grp.instr[i];
            end
        end
    end

    // Head straight from the queue
    always_comb begin
        for (int i = 0; i < ID_WIDTH; i++) begin
            head_o[i]       = queue[rd_idx[i]];
            head_valid_o[i] = (int'(count) > i);
        end
    end

    assign grp.stall = (int'(count) > STALL_LVL);

endmodule

// File: source/instr_decode.sv
`timescale 1ns/100ps

module instr_decode #(
    parameter int ID_WIDTH = 2
) (
    input  fe_pkg::ibuf_entry_t      head_i [ID_WIDTH],
    input  logic [ID_WIDTH-1:0]      head_valid_i,
    output logic [ID_WIDTH-1:0]      dec_valid_o,
    output logic [fe_pkg::XLEN-1:0]  dec_pc_o [ID_WIDTH],
    output fe_pkg::op_e              dec_op_o [ID_WIDTH],
    output logic [fe_pkg::REG_W-1:0] dec_rd_o [ID_WIDTH],
    output logic [fe_pkg::REG_W-1:0] dec_rs1_o [ID_WIDTH],
    output logic [fe_pkg::REG_W-1:0] dec_rs2_o [ID_WIDTH],
    output logic [fe_pkg::XLEN-1:0]  dec_imm_o [ID_WIDTH],
    output logic [ID_WIDTH-1:0]      dec_wb_o
);

    assign dec_valid_o = head_valid_i;

    // Each slot decoded on its own
    always_comb begin
        logic [fe_pkg::XLEN-1:0] word;
        logic [3:0]              opc;
        fe_pkg::op_e             op;
        for (int i = 0; i < ID_WIDTH; i++) begin
            word = head_i[i].instr;
            opc  = word[fe_pkg::OPC_MSB:fe_pkg::OPC_LSB];

            // Opcode field to enum
            case (opc)
                4'd0:    op = fe_pkg::OP_ADD;
                4'd1:    op = fe_pkg::OP_SUB;
                4'd2:    op = fe_pkg::OP_AND;
                4'd3:    op = fe_pkg::OP_OR;
                4'd4:    op = fe_pkg::OP_XOR;
                4'd5:    op = fe_pkg::OP_LOAD;
                4'd6:    op = fe_pkg::OP_STORE;
                4'd7:    op = fe_pkg::OP_BRANCH;
                default: op = fe_pkg::OP_ILLEGAL;
            endcase

            dec_pc_o[i]  = head_i[i].pc;
            dec_op_o[i]  = op;
            dec_rd_o[i]  = word[fe_pkg::RD_MSB:fe_pkg::RD_LSB];
            dec_rs1_o[i] = word[fe_pkg::RS1_MSB:fe_pkg::RS1_LSB];
            dec_rs2_o[i] = word[fe_pkg::RS2_MSB:fe_pkg::RS2_LSB];

            // Sign extend the immediate
            dec_imm_o[i] = {{(fe_pkg::XLEN - fe_pkg::IMM_W){word[fe_pkg::IMM_MSB]}},
                            word[fe_pkg::IMM_MSB:fe_pkg::IMM_LSB]};

            // Stores, branches and illegal words leave rd alone
            case (op)
                fe_pkg::OP_STORE,
                fe_pkg::OP_BRANCH,
                fe_pkg::OP_ILLEGAL: dec_wb_o[i] = 1'b0;
                default:            dec_wb_o[i] = 1'b1;
            endcase
        end
    end

endmodule

// File: source/fetch_decode_top.sv
`timescale 1ns/100ps

module fetch_decode_top #(
    parameter int IF_WIDTH    = 2,
    parameter int ID_WIDTH    = 2,
    parameter int BUFFER_SIZE = 8
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // Instruction memory, fixed one-cycle latency
    output logic                             imem_req_o,
    output logic [fe_pkg::XLEN-1:0]          imem_addr_o,
    input  logic [IF_WIDTH*fe_pkg::XLEN-1:0] imem_rdata_i,
    // Backend
    input  logic                             redirect_i,
    input  logic [fe_pkg::XLEN-1:0]          redirect_pc_i,
    input  logic [ID_WIDTH-1:0]              dec_accept_i,
    output logic [ID_WIDTH-1:0]              dec_valid_o,
    output logic [fe_pkg::XLEN-1:0]          dec_pc_o [ID_WIDTH],
    output fe_pkg::op_e                      dec_op_o [ID_WIDTH],
    output logic [fe_pkg::REG_W-1:0]         dec_rd_o [ID_WIDTH],
    output logic [fe_pkg::REG_W-1:0]         dec_rs1_o [ID_WIDTH],
    output logic [fe_pkg::REG_W-1:0]         dec_rs2_o [ID_WIDTH],
    output logic [fe_pkg::XLEN-1:0]          dec_imm_o [ID_WIDTH],
    output logic [ID_WIDTH-1:0]              dec_wb_o
);

    // Buffer head toward decode
    fe_pkg::ibuf_entry_t head [ID_WIDTH];
    logic [ID_WIDTH-1:0] head_valid;

    fetch_group_if #(.IF_WIDTH(IF_WIDTH)) grp_if ();

    instr_fetch #(.IF_WIDTH(IF_WIDTH)) u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .redirect_i   (redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .imem_rdata_i (imem_rdata_i),
        .grp          (grp_if.fetch)
    );

    // Redirect doubles as the buffer flush
    instr_buffer #(
        .IF_WIDTH   (IF_WIDTH),
        .ID_WIDTH   (ID_WIDTH),
        .BUFFER_SIZE(BUFFER_SIZE)
    ) u_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (redirect_i),
        .grp         (grp_if.buffer),
        .accept_i    (dec_accept_i),
        .head_o      (head),
        .head_valid_o(head_valid)
    );

    instr_decode #(.ID_WIDTH(ID_WIDTH)) u_decode (
        .head_i      (head),
        .head_valid_i(head_valid),
        .dec_valid_o (dec_valid_o),
        .dec_pc_o    (dec_pc_o),
        .dec_op_o    (dec_op_o),
        .dec_rd_o    (dec_rd_o),
        .dec_rs1_o   (dec_rs1_o),
        .dec_rs2_o   (dec_rs2_o),
        .dec_imm_o   (dec_imm_o),
        .dec_wb_o    (dec_wb_o)
    );

endmodule

// File: dv/tb_fetch_decode.sv
`timescale 1ns/100ps

module tb_fetch_decode;

    localparam int IF_WIDTH    = 2;
    localparam int ID_WIDTH    = 2;
    localparam int BUFFER_SIZE = 8;
    localparam int N_CYCLES    = 2000;
    // Cycles allowed without a valid slot
    localparam int TIMEOUT     = 20;

    logic                             clk;
    logic                             rst_n;
    logic                             imem_req_o;
    logic [31:0]                      imem_addr_o;
    logic [IF_WIDTH*32-1:0]           imem_rdata_i;
    logic                             redirect_i;
    logic [31:0]                      redirect_pc_i;
    logic [ID_WIDTH-1:0]              dec_accept_i;
    logic [ID_WIDTH-1:0]              dec_valid_o;
    logic [31:0]                      dec_pc_o [ID_WIDTH];
    fe_pkg::op_e                      dec_op_o [ID_WIDTH];
    logic [3:0]                       dec_rd_o [ID_WIDTH];
    logic [3:0]                       dec_rs1_o [ID_WIDTH];
    logic [3:0]                       dec_rs2_o [ID_WIDTH];
    logic [31:0]                      dec_imm_o [ID_WIDTH];
    logic [ID_WIDTH-1:0]              dec_wb_o;

    // Memory model and its one pending request
    logic [31:0] mem [256];
    integer      seed;
    logic        req_q;
    logic [31:0] addr_q;
    // Next PC the backend expects to accept
    logic [31:0] exp_pc;

    fetch_decode_top #(
        .IF_WIDTH   (IF_WIDTH),
        .ID_WIDTH   (ID_WIDTH),
        .BUFFER_SIZE(BUFFER_SIZE)
    ) uut (
        .clk(clk), .rst_n(rst_n),
        .imem_req_o(imem_req_o), .imem_addr_o(imem_addr_o), .imem_rdata_i(imem_rdata_i),
        .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i), .dec_accept_i(dec_accept_i),
        .dec_valid_o(dec_valid_o), .dec_pc_o(dec_pc_o), .dec_op_o(dec_op_o),
        .dec_rd_o(dec_rd_o), .dec_rs1_o(dec_rs1_o), .dec_rs2_o(dec_rs2_o),
        .dec_imm_o(dec_imm_o), .dec_wb_o(dec_wb_o)
    );

    always #50 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    // Next cycle, then answer last cycle's request and clear the pulses
    task automatic step();
        @(posedge clk);
        #10;
        for (int j = 0; j < IF_WIDTH; j++) begin
            if (req_q)
                imem_rdata_i[j*32 +: 32] = mem[8'(addr_q + 32'(j))];
            else
                imem_rdata_i[j*32 +: 32] = $random(seed);
        end
        req_q        = imem_req_o;
        addr_q       = imem_addr_o;
        redirect_i   = 1'b0;
        dec_accept_i = '0;
    endtask

    task automatic wait_valid(input string why);
        int n;
        n = 0;
        while (!dec_valid_o[0] && n < TIMEOUT) begin
            step();
            n++;
        end
        if (!dec_valid_o[0]) abort_run(why);
    endtask

    // Expected decode of the memory word at the expected PC
    task automatic check_slot(input int i);
        logic [31:0] w;
        logic [3:0]  f;
        w = mem[exp_pc[7:0]];
        f = w[31:28];
        check_val($sformatf("dec_pc_o[%0d]", i), exp_pc, dec_pc_o[i]);
        check_val($sformatf("dec_op_o[%0d]", i), (f < 8) ? 32'(f) : 32'd8, 32'(dec_op_o[i]));
        check_val($sformatf("dec_rd_o[%0d]", i), 32'(w[27:24]), 32'(dec_rd_o[i]));
        check_val($sformatf("dec_rs1_o[%0d]", i), 32'(w[23:20]), 32'(dec_rs1_o[i]));
        check_val($sformatf("dec_rs2_o[%0d]", i), 32'(w[19:16]), 32'(dec_rs2_o[i]));
        check_val($sformatf("dec_imm_o[%0d]", i), {{16{w[15]}}, w[15:0]}, dec_imm_o[i]);
        // ADD through LOAD write rd
        check_val($sformatf("dec_wb_o[%0d]", i), (f < 6) ? 32'd1 : 32'd0, 32'(dec_wb_o[i]));
        exp_pc = exp_pc + 1;
    endtask

    initial begin
        int                  nvalid;
        int                  k;
        int                  hold_left;
        int                  idle;
        logic [ID_WIDTH-1:0] prev_valid;
        logic [31:0]         prev_pc0;
        clk           = 1'b0;
        rst_n         = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        dec_accept_i  = '0;
        imem_rdata_i  = '0;
        req_q         = 1'b0;
        addr_q        = '0;
        exp_pc        = '0;
        hold_left     = 0;
        idle          = 0;
        prev_valid    = '0;
        prev_pc0      = '0;
        seed          = 1086;
        for (int a = 0; a < 256; a++) mem[a] = $random(seed);

        // Quiet during reset
        repeat (2) begin
            step();
            check_val("imem_req_o", 0, 32'(imem_req_o));
            check_val("dec_valid_o", 0, 32'(dec_valid_o));
        end
        rst_n = 1'b1;
        step();
        // First cycle out of reset requests PC 0
        check_val("imem_req_o", 1, 32'(imem_req_o));
        check_val("imem_addr_o", 0, imem_addr_o);
        check_val("dec_valid_o", 0, 32'(dec_valid_o));
        wait_valid("no valid slot within the timeout after reset");
        check_val("dec_pc_o[0]", 0, dec_pc_o[0]);

        for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
            // Valid must be a prefix
            check_val("dec_valid_o prefix", 0, (32'(dec_valid_o) + 1) & 32'(dec_valid_o));
            // Held outputs while nothing was accepted
            if (prev_valid[0]) begin
                check_val("dec_valid_o", 32'(prev_valid), 32'(dec_valid_o & prev_valid));
                check_val("dec_pc_o[0]", prev_pc0, dec_pc_o[0]);
            end
            idle = dec_valid_o[0] ? 0 : idle + 1;
            if (idle > TIMEOUT) abort_run("decode outputs starved of valid slots");
            nvalid = 0;
            for (int i = 0; i < ID_WIDTH; i++) nvalid += int'(dec_valid_o[i]);

            if (($unsigned($random(seed)) % 40) == 0) begin
                // Branch miss to a random, possibly unaligned PC
                redirect_i    = 1'b1;
                redirect_pc_i = $random(seed) & 32'h3ff;
                exp_pc        = redirect_pc_i;
                prev_valid    = '0;
                step();
                check_val("dec_valid_o", 0, 32'(dec_valid_o));
                // Target group requested right after the redirect
                check_val("imem_req_o", 1, 32'(imem_req_o));
                check_val("imem_addr_o", exp_pc - exp_pc % 32'(IF_WIDTH), imem_addr_o);
                wait_valid("no valid slot within the timeout after a redirect");
            end else begin
                // Zero-accept bursts now and then
                if (hold_left == 0 && ($unsigned($random(seed)) % 16) == 0)
                    hold_left = $unsigned($random(seed)) % 30;
                if (hold_left > 0) begin
                    k = 0;
                    hold_left--;
                end else begin
                    k = $unsigned($random(seed)) % (nvalid + 1);
                end
                for (int i = 0; i < k; i++) check_slot(i);
                dec_accept_i = ID_WIDTH'((1 << k) - 1);
                prev_valid   = (k == 0) ? dec_valid_o : '0;
                prev_pc0     = dec_pc_o[0];
                step();
            end
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: fetch_decode_core.f
source/fe_pkg.sv
source/fetch_group_if.sv
source/instr_fetch.sv
source/instr_buffer.sv
source/instr_decode.sv
source/fetch_decode_top.sv
dv/tb_fetch_decode.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_fetch_decode \
		-f fetch_decode_core.f
	out=$$(./obj_dir/Vtb_fetch_decode); echo "$$out"; \
		echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
